// File: Bender.yml
package:
  name: rv32_core

sources:
  - source/rv32_pkg.sv
  - source/rv32_fetch_stage.sv
  - source/rv32_decoder.sv
  - source/rv32_hazard_unit.sv
  - source/rv32_decode_stage.sv
  - source/rv32_regfile.sv
  - source/rv32_exec_stage.sv
  - source/rv32_core.sv
  - target: test
    files:
      - dv/rv32_core_tb.sv

// File: all.f
source/rv32_pkg.sv
source/rv32_fetch_stage.sv
source/rv32_decoder.sv
source/rv32_hazard_unit.sv
source/rv32_decode_stage.sv
source/rv32_regfile.sv
source/rv32_exec_stage.sv
source/rv32_core.sv
dv/rv32_core_tb.sv

// File: dv/rv32_core_tb.sv
`timescale 1ns/1ps

module rv32_core_tb
    import rv32_pkg::*;
();

    logic       clk;
    logic       resetn;
    logic       stop;
    rv32_word   instr_addr;
    rv32_word   instr_rdata;
    rv32_word   data_addr;
    rv32_word   data_rdata;
    logic       wb_valid;
    rv_reg_id_t wb_rd;
    rv32_word   wb_data;

    rv32_word   imem [64];
    rv32_word   dmem [16];
    rv_reg_id_t exp_rd [32];
    rv32_word   exp_val [32];
    rv32_word   exp_addr [32];
    string      exp_name [32];
    int         exp_count;
    int         ret_idx;
    int         errors;
    int         seed;
    int         burst_left;

    rv32_core rv32_core_inst (
        .clk        (clk),
        .resetn     (resetn),
        .stop       (stop),
        .instr_addr (instr_addr),
        .instr_rdata(instr_rdata),
        .data_addr  (data_addr),
        .data_rdata (data_rdata),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Both memories answer in the same cycle
    assign instr_rdata = (instr_addr[31:8] == '0) ? imem[instr_addr[7:2]] : RV_NOP;
    assign data_rdata  = dmem[data_addr[5:2]];

    function automatic rv32_word encode_r(logic [6:0] f7, rv_reg_id_t rs2, rv_reg_id_t rs1,
                                          logic [2:0] f3, rv_reg_id_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic rv32_word encode_i(logic [11:0] imm, rv_reg_id_t rs1, logic [2:0] f3,
                                          rv_reg_id_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv32_word encode_lui(logic [19:0] imm, rv_reg_id_t rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic rv32_word encode_b(logic [12:0] off, rv_reg_id_t rs2, rv_reg_id_t rs1,
                                          logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    // Non-loads show their own result on data_addr
    task automatic add_expect(string name, rv_reg_id_t rd, rv32_word value);
        exp_name[exp_count] = name;
        exp_rd[exp_count]   = rd;
        exp_val[exp_count]  = value;
        exp_addr[exp_count] = value;
        exp_count++;
    endtask

    // A load shows its address instead
    task automatic set_load_addr(rv32_word addr);
        exp_addr[exp_count-1] = addr;
    endtask

    task automatic load_program();
        // Unused slots hold addi x0 with the slot index and never retire
        for (int i = 0; i < 64; i++) begin
            imem[i] = encode_i(12'(i), 0, 3'b000, 0, OPC_OP_IMM);
        end
        for (int i = 0; i < 16; i++) begin
            dmem[i] = 32'h5A00_0000 + (i << 16) + (i << 2);
        end
        imem[0]  = encode_i(12'd5, 0, 3'b000, 1, OPC_OP_IMM);
        imem[1]  = encode_i(12'd7, 1, 3'b000, 2, OPC_OP_IMM);
        imem[2]  = encode_r(7'h00, 2, 1, 3'b000, 3);
        imem[3]  = encode_r(7'h20, 1, 3, 3'b000, 4);
        imem[4]  = encode_r(7'h00, 3, 4, 3'b100, 5);
        imem[5]  = encode_i(12'hffd, 0, 3'b000, 6, OPC_OP_IMM);
        imem[6]  = encode_r(7'h00, 5, 6, 3'b010, 7);
        imem[7]  = encode_r(7'h00, 7, 5, 3'b001, 8);
        imem[8]  = encode_lui(20'h12345, 9);
        imem[9]  = encode_r(7'h00, 8, 9, 3'b000, 10);
        // Load followed at once by its consumer
        imem[10] = encode_i(12'd8, 0, 3'b000, 11, OPC_OP_IMM);
        imem[11] = encode_i(12'd0, 11, 3'b010, 12, OPC_LOAD);
        imem[12] = encode_r(7'h00, 11, 12, 3'b000, 13);
        imem[13] = encode_i(12'd4, 11, 3'b010, 14, OPC_LOAD);
        imem[14] = encode_r(7'h20, 12, 14, 3'b000, 15);
        imem[15] = encode_i(12'd99, 0, 3'b000, 0, OPC_OP_IMM);
        imem[16] = encode_r(7'h00, 1, 0, 3'b000, 16);
        // Not-taken bne and then a beq taken over two slots
        imem[17] = encode_b(13'd16, 4, 2, 3'b001);
        imem[18] = encode_i(12'd1, 16, 3'b000, 17, OPC_OP_IMM);
        imem[19] = encode_b(13'd12, 16, 1, 3'b000);
        imem[20] = encode_i(12'd111, 0, 3'b000, 18, OPC_OP_IMM);
        imem[21] = encode_i(12'd222, 0, 3'b000, 19, OPC_OP_IMM);
        imem[22] = encode_i(12'd100, 17, 3'b000, 20, OPC_OP_IMM);
        imem[23] = encode_r(7'h00, 20, 20, 3'b000, 21);

        add_expect("alu_bypass", 1, 32'd5);
        add_expect("alu_bypass", 2, 32'd12);
        add_expect("alu_bypass", 3, 32'd17);
        add_expect("alu_bypass", 4, 32'd12);
        add_expect("alu_bypass", 5, 32'h0000_001D);
        add_expect("alu_bypass", 6, 32'hFFFF_FFFD);
        add_expect("alu_bypass", 7, 32'd1);
        add_expect("alu_bypass", 8, 32'h0000_003A);
        add_expect("alu_bypass", 9, 32'h1234_5000);
        add_expect("alu_bypass", 10, 32'h1234_503A);
        add_expect("load_use", 11, 32'd8);
        add_expect("load_use", 12, 32'h5A02_0008);
        set_load_addr(32'd8);
        add_expect("load_use", 13, 32'h5A02_0010);
        add_expect("load_use", 14, 32'h5A03_000C);
        set_load_addr(32'd12);
        add_expect("load_use", 15, 32'h0001_0004);
        add_expect("x0_read", 16, 32'd5);
        add_expect("branch", 17, 32'd6);
        add_expect("branch", 20, 32'd106);
        add_expect("branch", 21, 32'd212);
    endtask

    task automatic check_value(string name, rv32_word expected, rv32_word actual);
        assert (actual === expected)
        else begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // One clock and the stop level for the next cycle
    task automatic advance_cycle();
        @(posedge clk);
        #1;
        if (burst_left == 0 && ($random(seed) & 7) == 0) begin
            burst_left = 1 + ($random(seed) & 3);
        end
        stop = (burst_left != 0);
        if (burst_left != 0) begin
            burst_left--;
        end
    endtask

    always @(posedge clk) begin
        if (!resetn) begin
            ret_idx <= 0;
        end else if (wb_valid) begin
            ret_idx <= ret_idx + 1;
        end
    end

    assert property (@(posedge clk) disable iff (!resetn)
        wb_valid && ret_idx < exp_count |->
            wb_rd == exp_rd[ret_idx] && wb_data == exp_val[ret_idx])
    else begin
        errors++;
        $display("CHECK FAILED %s: expected x%0d = %h, actual x%0d = %h",
                 exp_name[$sampled(ret_idx)], exp_rd[$sampled(ret_idx)],
                 exp_val[$sampled(ret_idx)], $sampled(wb_rd), $sampled(wb_data));
    end

    assert property (@(posedge clk) disable iff (!resetn)
        wb_valid && ret_idx < exp_count |-> data_addr == exp_addr[ret_idx])
    else begin
        errors++;
        $display("CHECK FAILED %s: expected data_addr %h, actual data_addr %h",
                 exp_name[$sampled(ret_idx)], exp_addr[$sampled(ret_idx)],
                 $sampled(data_addr));
    end

    assert property (@(posedge clk) disable iff (!resetn) wb_valid |-> ret_idx < exp_count)
    else begin
        errors++;
        $display("Unexpected retirement of x%0d after the last expected one", $sampled(wb_rd));
    end

    assert property (@(posedge clk) disable iff (!resetn) stop |-> !wb_valid)
    else begin
        errors++;
        $display("wb_valid was high while stop was high");
    end

    // A stopped edge leaves the PC where it was
    assert property (@(posedge clk) disable iff (!resetn) stop |=> $stable(instr_addr))
    else begin
        errors++;
        $display("instr_addr moved across a stopped edge");
    end

    initial begin
        int   target;
        int   waited;
        logic timed_out;
        resetn     = 1'b0;
        stop       = 1'b0;
        errors     = 0;
        exp_count  = 0;
        burst_left = 0;
        seed       = 6354;
        timed_out  = 1'b0;
        load_program();
        repeat (3) @(posedge clk);
        #1;
        resetn = 1'b1;
        check_value("reset_pc", 32'd0, instr_addr);
        check_value("reset_wb_valid", 32'd0, 32'(wb_valid));
        // First instruction retires only after its third edge
        repeat (2) begin
            @(posedge clk);
            #1;
            check_value("reset_wb_valid", 32'd0, 32'(wb_valid));
        end

        while (ret_idx < exp_count && !timed_out) begin
            target = ret_idx;
            waited = 0;
            while (ret_idx == target && waited < 50) begin
                advance_cycle();
                waited++;
            end
            if (ret_idx == target) begin
                errors++;
                timed_out = 1'b1;
                $display("Timeout: retirement %0d of %0d did not appear within 50 cycles",
                         target + 1, exp_count);
            end
        end

        // Drain with stop low so nothing more may retire
        stop = 1'b0;
        repeat (10) begin
            @(posedge clk);
            #1;
        end

        $display("Errors: %0d, retirements seen: %0d of %0d", errors, ret_idx, exp_count);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: source/rv32_core.sv
`timescale 1ns/1ps

module rv32_core
    import rv32_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       stop,
    output rv32_word   instr_addr,
    input  rv32_word   instr_rdata,
    output rv32_word   data_addr,
    input  rv32_word   data_rdata,
    output logic       wb_valid,
    output rv_reg_id_t wb_rd,
    output rv32_word   wb_data
);

    fetch_decode_buffer_t fetch_decode_buff;
    decode_exec_buffer_t  decode_exec_buff;
    exec_mem_buffer_t     exec_mem_buff;
    logic                 stall;
    logic                 branch_taken;
    rv32_word             branch_target;
    rv_reg_id_t           rs1;
    rv_reg_id_t           rs2;
    rv32_word             reg1;
    rv32_word             reg2;
    rv32_word             wb_value;

    assign data_addr = exec_mem_buff.alu_result;

    rv32_fetch_stage fetch_inst (
        .clk              (clk),
        .resetn           (resetn),
        .stop             (stop),
        .stall            (stall),
        .branch_taken     (branch_taken),
        .branch_target    (branch_target),
        .instr_addr       (instr_addr),
        .instr_rdata      (instr_rdata),
        .fetch_decode_buff(fetch_decode_buff)
    );

    // Taken branch flushes decode as well
    rv32_decode_stage decode_inst (
        .clk              (clk),
        .resetn           (resetn),
        .set_nop          (branch_taken),
        .stop             (stop),
        .set_nop_pc       (branch_target),
        .fetch_decode_buff(fetch_decode_buff),
        .decode_exec_buff (decode_exec_buff),
        .stall            (stall),
        .rs1              (rs1),
        .rs2              (rs2),
        .reg1             (reg1),
        .reg2             (reg2),
        .exec_mem_buff    (exec_mem_buff)
    );

    rv32_exec_stage exec_inst (
        .clk             (clk),
        .resetn          (resetn),
        .stop            (stop),
        .decode_exec_buff(decode_exec_buff),
        .wb_value        (wb_value),
        .exec_mem_buff   (exec_mem_buff),
        .branch_taken    (branch_taken),
        .branch_target   (branch_target)
    );

    rv32_regfile regfile_inst (
        .clk          (clk),
        .resetn       (resetn),
        .stop         (stop),
        .rs1          (rs1),
        .rs2          (rs2),
        .reg1         (reg1),
        .reg2         (reg2),
        .exec_mem_buff(exec_mem_buff),
        .data_rdata   (data_rdata),
        .wb_value     (wb_value),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data)
    );

endmodule

// File: source/rv32_decode_stage.sv
`timescale 1ns/1ps

module rv32_decode_stage
    import rv32_pkg::*;
(
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 set_nop,
    input  logic                 stop,
    input  rv32_word             set_nop_pc,
    input  fetch_decode_buffer_t fetch_decode_buff,
    output decode_exec_buffer_t  decode_exec_buff,
    output logic                 stall,
    output rv_reg_id_t           rs1,
    output rv_reg_id_t           rs2,
    input  rv32_word             reg1,
    input  rv32_word             reg2,
    input  exec_mem_buffer_t     exec_mem_buff
);

    decode_exec_buffer_t next_buff;
    decoded_instr_t      dec_ctrl;
    logic [1:0]          use_rs;
    bypass_t             bypass_rs [2];

    rv32_decoder decoder_inst (
        .instr        (fetch_decode_buff.instr),
        .decoded_instr(dec_ctrl),
        .use_rs       (use_rs)
    );

    rv32_hazard_unit hazard_inst (
        .use_rs          (use_rs),
        .current_instr   (fetch_decode_buff.instr),
        .decode_exec_buff(decode_exec_buff),
        .exec_mem_buff   (exec_mem_buff),
        .stall           (stall),
        .bypass_rs       (bypass_rs)
    );

    // Register file read addresses
    assign rs1 = fetch_decode_buff.instr.rs1;
    assign rs2 = fetch_decode_buff.instr.rs2;

    always_comb begin
        next_buff.pc                       = fetch_decode_buff.pc;
        next_buff.instr                    = fetch_decode_buff.instr;
        next_buff.reg1                     = reg1;
        next_buff.reg2                     = reg2;
        next_buff.decoded_instr            = dec_ctrl;
        next_buff.decoded_instr.bypass_rs1 = bypass_rs[0];
        next_buff.decoded_instr.bypass_rs2 = bypass_rs[1];

        // Bubble into exec on load-use or branch flush
        if (stall || set_nop) begin
            next_buff.instr         = RV_NOP;
            next_buff.decoded_instr = create_nop_ctrl();
        end
        if (set_nop) begin
            next_buff.pc = set_nop_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            decode_exec_buff.pc            <= '0;
            decode_exec_buff.instr         <= RV_NOP;
            decode_exec_buff.reg1          <= '0;
            decode_exec_buff.reg2          <= '0;
            decode_exec_buff.decoded_instr <= create_nop_ctrl();
        end else if (!stop) begin
            decode_exec_buff <= next_buff;
        end
    end

endmodule

// File: source/rv32_decoder.sv
`timescale 1ns/1ps

module rv32_decoder
    import rv32_pkg::*;
(
    input  rv32_instr_t    instr,
    output decoded_instr_t decoded_instr,
    output logic [1:0]     use_rs
);

    rv32_word raw;
    rv32_word imm_i;
    rv32_word imm_u;
    rv32_word imm_b;
    logic     known;

    assign raw   = instr;
    assign imm_i = {{20{raw[31]}}, raw[31:20]};
    assign imm_u = {raw[31:12], 12'b0};
    assign imm_b = {{19{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};

    always_comb begin
        decoded_instr = create_nop_ctrl();
        use_rs        = 2'b00;
        known         = 1'b1;

        // Bit 0 is rs1, bit 1 is rs2
        case (instr.opcode)
            OPC_OP: begin
                use_rs = 2'b11;
                known  = (instr.funct7 == 7'b0000000) ||
                         (instr.funct7 == 7'b0100000 && instr.funct3 == 3'b000);
                case (instr.funct3)
                    3'b000:  decoded_instr.alu_op = instr.funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b001:  decoded_instr.alu_op = ALU_SLL;
                    3'b010:  decoded_instr.alu_op = ALU_SLT;
                    3'b100:  decoded_instr.alu_op = ALU_XOR;
                    3'b101:  decoded_instr.alu_op = ALU_SRL;
                    3'b110:  decoded_instr.alu_op = ALU_OR;
                    3'b111:  decoded_instr.alu_op = ALU_AND;
                    default: known = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                use_rs                = 2'b01;
                decoded_instr.use_imm = 1'b1;
                decoded_instr.imm     = imm_i;
                case (instr.funct3)
                    3'b000:  decoded_instr.alu_op = ALU_ADD;
                    3'b010:  decoded_instr.alu_op = ALU_SLT;
                    3'b100:  decoded_instr.alu_op = ALU_XOR;
                    3'b110:  decoded_instr.alu_op = ALU_OR;
                    3'b111:  decoded_instr.alu_op = ALU_AND;
                    default: known = 1'b0;
                endcase
            end
            OPC_LUI: begin
                decoded_instr.alu_op  = ALU_PASS_B;
                decoded_instr.use_imm = 1'b1;
                decoded_instr.imm     = imm_u;
            end
            OPC_LOAD: begin
                use_rs                = 2'b01;
                known                 = (instr.funct3 == F3_LW);
                decoded_instr.use_imm = 1'b1;
                decoded_instr.imm     = imm_i;
                decoded_instr.is_load = 1'b1;
            end
            OPC_BRANCH: begin
                use_rs                  = 2'b11;
                known                   = (instr.funct3 == F3_BEQ) || (instr.funct3 == F3_BNE);
                decoded_instr.imm       = imm_b;
                decoded_instr.is_branch = 1'b1;
                decoded_instr.branch_ne = (instr.funct3 == F3_BNE);
            end
            default: known = 1'b0;
        endcase

        // Everything but branches writes rd, x0 excepted
        if (!decoded_instr.is_branch && instr.rd != '0) begin
            decoded_instr.reg_write = 1'b1;
            decoded_instr.rd        = instr.rd;
        end

        if (!known) begin
            decoded_instr = create_nop_ctrl();
            use_rs        = 2'b00;
        end
    end

endmodule

// File: source/rv32_exec_stage.sv
`timescale 1ns/1ps

module rv32_exec_stage
    import rv32_pkg::*;
(
    input  logic                clk,
    input  logic                resetn,
    input  logic                stop,
    input  decode_exec_buffer_t decode_exec_buff,
    input  rv32_word            wb_value,
    output exec_mem_buffer_t    exec_mem_buff,
    output logic                branch_taken,
    output rv32_word            branch_target
);

    decoded_instr_t ctrl;
    rv32_word       op1;
    rv32_word       op2;
    rv32_word       alu_b;
    rv32_word       alu_result;
    rv32_word       wb_hold;

    function automatic rv32_word pick_operand(bypass_t sel, rv32_word reg_val,
                                              rv32_word exec_val, rv32_word wb_val);
        case (sel)
            BYP_EXEC: return exec_val;
            BYP_WB:   return wb_val;
            default:  return reg_val;
        endcase
    endfunction

    assign ctrl  = decode_exec_buff.decoded_instr;
    assign op1   = pick_operand(ctrl.bypass_rs1, decode_exec_buff.reg1,
                                exec_mem_buff.alu_result, wb_hold);
    assign op2   = pick_operand(ctrl.bypass_rs2, decode_exec_buff.reg2,
                                exec_mem_buff.alu_result, wb_hold);
    assign alu_b = ctrl.use_imm ? ctrl.imm : op2;

    // Load address is op1 + imm through the ADD path
    always_comb begin
        case (ctrl.alu_op)
            ALU_SUB:    alu_result = op1 - alu_b;
            ALU_AND:    alu_result = op1 & alu_b;
            ALU_OR:     alu_result = op1 | alu_b;
            ALU_XOR:    alu_result = op1 ^ alu_b;
            ALU_SLT:    alu_result = {31'b0, $signed(op1) < $signed(alu_b)};
            ALU_SLL:    alu_result = op1 << alu_b[4:0];
            ALU_SRL:    alu_result = op1 >> alu_b[4:0];
            ALU_PASS_B: alu_result = alu_b;
            default:    alu_result = op1 + alu_b;
        endcase
    end

    assign branch_taken  = ctrl.is_branch && ((op1 == op2) != ctrl.branch_ne) && !stop;
    assign branch_target = decode_exec_buff.pc + ctrl.imm;

    // Value that retired while the current instruction sat in decode
    always_ff @(posedge clk) begin
        if (!stop) begin
            wb_hold <= wb_value;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            exec_mem_buff.instr      <= RV_NOP;
            exec_mem_buff.rd         <= '0;
            exec_mem_buff.reg_write  <= 1'b0;
            exec_mem_buff.is_load    <= 1'b0;
            exec_mem_buff.alu_result <= '0;
        end else if (!stop) begin
            exec_mem_buff.instr      <= decode_exec_buff.instr;
            exec_mem_buff.rd         <= ctrl.rd;
            exec_mem_buff.reg_write  <= ctrl.reg_write;
            exec_mem_buff.is_load    <= ctrl.is_load;
            exec_mem_buff.alu_result <= alu_result;
        end
    end

endmodule

// File: source/rv32_fetch_stage.sv
`timescale 1ns/1ps

module rv32_fetch_stage
    import rv32_pkg::*;
(
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 stop,
    input  logic                 stall,
    input  logic                 branch_taken,
    input  rv32_word             branch_target,
    output rv32_word             instr_addr,
    input  rv32_instr_t          instr_rdata,
    output fetch_decode_buffer_t fetch_decode_buff
);

    rv32_word pc;

    assign instr_addr = pc;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc                      <= '0;
            fetch_decode_buff.pc    <= '0;
            fetch_decode_buff.instr <= RV_NOP;
        end else if (!stop) begin
            if (branch_taken) begin
                // Squash the slot being fetched and redirect
                pc                      <= branch_target;
                fetch_decode_buff.pc    <= pc;
                fetch_decode_buff.instr <= RV_NOP;
            end else if (!stall) begin
                pc                      <= pc + 32'd4;
                fetch_decode_buff.pc    <= pc;
                fetch_decode_buff.instr <= instr_rdata;
            end
        end
    end

endmodule

// File: source/rv32_hazard_unit.sv
`timescale 1ns/1ps

module rv32_hazard_unit
    import rv32_pkg::*;
(
    input  logic [1:0]          use_rs,
    input  rv32_instr_t         current_instr,
    input  decode_exec_buffer_t decode_exec_buff,
    input  exec_mem_buffer_t    exec_mem_buff,
    output logic                stall,
    output bypass_t             bypass_rs [2]
);

    rv_reg_id_t     src_id [2];
    decoded_instr_t ahead_one;

    assign src_id[0] = current_instr.rs1;
    assign src_id[1] = current_instr.rs2;
    assign ahead_one = decode_exec_buff.decoded_instr;

    always_comb begin
        stall = 1'b0;
        for (int i = 0; i < 2; i++) begin
            bypass_rs[i] = BYP_NONE;
            if (use_rs[i] && src_id[i] != '0) begin
                // Younger producer checked first
                if (ahead_one.reg_write && ahead_one.rd == src_id[i]) begin
                    if (ahead_one.is_load) begin
                        // Load data not ready until it reaches mem
                        stall = 1'b1;
                    end else begin
                        bypass_rs[i] = BYP_EXEC;
                    end
                end else if (exec_mem_buff.reg_write && exec_mem_buff.rd == src_id[i]) begin
                    bypass_rs[i] = BYP_WB;
                end
            end
        end
    end

endmodule

// File: source/rv32_pkg.sv
package rv32_pkg;

    localparam int XLEN     = 32;
    localparam int REG_ID_W = 5;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0]     rv32_word;
    typedef logic [REG_ID_W-1:0] rv_reg_id_t;

    // Base instruction fields, R-type layout
    typedef struct packed {
        logic [6:0] funct7;
        rv_reg_id_t rs2;
        rv_reg_id_t rs1;
        logic [2:0] funct3;
        rv_reg_id_t rd;
        logic [6:0] opcode;
    } rv32_instr_t;

    // ADDI x0, x0, 0
    localparam rv32_word RV_NOP = 32'h0000_0013;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_t;

    // Operand source chosen in decode, applied in exec
    typedef enum logic [1:0] {
        BYP_NONE,
        BYP_EXEC,
        BYP_WB
    } bypass_t;

    typedef struct packed {
        alu_op_t    alu_op;
        logic       use_imm;
        rv32_word   imm;
        logic       reg_write;
        rv_reg_id_t rd;
        logic       is_load;
        logic       is_branch;
        logic       branch_ne;
        bypass_t    bypass_rs1;
        bypass_t    bypass_rs2;
    } decoded_instr_t;

    function automatic decoded_instr_t create_nop_ctrl();
        decoded_instr_t ctrl;
        ctrl.alu_op     = ALU_ADD;
        ctrl.use_imm    = 1'b0;
        ctrl.imm        = '0;
        ctrl.reg_write  = 1'b0;
        ctrl.rd         = '0;
        ctrl.is_load    = 1'b0;
        ctrl.is_branch  = 1'b0;
        ctrl.branch_ne  = 1'b0;
        ctrl.bypass_rs1 = BYP_NONE;
        ctrl.bypass_rs2 = BYP_NONE;
        return ctrl;
    endfunction

    typedef struct packed {
        rv32_word    pc;
        rv32_instr_t instr;
    } fetch_decode_buffer_t;

    typedef struct packed {
        rv32_word       pc;
        rv32_instr_t    instr;
        rv32_word       reg1;
        rv32_word       reg2;
        decoded_instr_t decoded_instr;
    } decode_exec_buffer_t;

    typedef struct packed {
        rv32_instr_t instr;
        rv_reg_id_t  rd;
        logic        reg_write;
        logic        is_load;
        rv32_word    alu_result;
    } exec_mem_buffer_t;

endpackage

// File: source/rv32_regfile.sv
`timescale 1ns/1ps

module rv32_regfile
    import rv32_pkg::*;
(
    input  logic             clk,
    input  logic             resetn,
    input  logic             stop,
    input  rv_reg_id_t       rs1,
    input  rv_reg_id_t       rs2,
    output rv32_word         reg1,
    output rv32_word         reg2,
    input  exec_mem_buffer_t exec_mem_buff,
    input  rv32_word         data_rdata,
    output rv32_word         wb_value,
    output logic             wb_valid,
    output rv_reg_id_t       wb_rd,
    output rv32_word         wb_data
);

    rv32_word regs [NUM_REGS];
    logic     wr_en;

    // Load data comes straight off the data port
    assign wb_value = exec_mem_buff.is_load ? data_rdata : exec_mem_buff.alu_result;
    assign wr_en    = exec_mem_buff.reg_write && (exec_mem_buff.rd != '0) && !stop;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[exec_mem_buff.rd] <= wb_value;
        end
    end

    assign reg1 = (rs1 == '0) ? '0 : regs[rs1];
    assign reg2 = (rs2 == '0) ? '0 : regs[rs2];

    // Retire report
    assign wb_valid = wr_en;
    assign wb_rd    = exec_mem_buff.rd;
    assign wb_data  = wb_value;

endmodule
